// ==== Bender.yml ====
package:
  name: forthCore

sources:
  - cpuIsaPkg.sv
  - cpuCtrlPkg.sv
  - phaseSequencer.sv
  - instructionDecoder.sv
  - fullAlu.sv
  - registerFile.sv
  - programCounter.sv
  - forthCore.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbForthCore.sv

// ==== cpuCtrlPkg.sv ====
// Control definitions of the forth core.
// Instruction phases and the data path selects.
`default_nettype none

package cpuCtrlPkg;

	typedef enum logic [1:0] {
		phaseFetch   = 2'd0,
		phaseDecode  = 2'd1,
		phaseExecute = 2'd2,
		phaseCommit  = 2'd3
	} cpuPhase;

	// Source of the register write data.
	typedef enum logic [1:0] {
		selAlu  = 2'd0,
		selBus  = 2'd1,
		selNone = 2'd2
	} regDataSel;

	typedef enum logic {
		addrPc   = 1'b0,
		addrRegB = 1'b1
	} addrSel;

endpackage

`default_nettype wire

// ==== cpuIsaPkg.sv ====
// Instruction set of the forth core.
// Word type, instruction groups, ALU opcodes, jump conditions and field positions.
`default_nettype none

package cpuIsaPkg;

	typedef logic [15:0] dataWord;
	typedef logic [2:0] regIndex;

	typedef enum logic [1:0] {
		aluGroup  = 2'b00,
		memGroup  = 2'b01,
		jumpGroup = 2'b10,
		nopGroup  = 2'b11
	} instrGroup;

	typedef enum logic [3:0] {
		opAdd  = 4'd0,
		opSub  = 4'd1,
		opAnd  = 4'd2,
		opOr   = 4'd3,
		opXor  = 4'd4,
		opMov  = 4'd5,
		opAddi = 4'd6,
		opShl  = 4'd7,
		opShr  = 4'd8,
		opCmp  = 4'd9
	} aluOpcode;

	typedef enum logic [1:0] {
		condZero   = 2'd0,
		condCarry  = 2'd1,
		condSign   = 2'd2,
		condParity = 2'd3
	} condSelect;

	// Common fields.
	localparam int groupMsb = 15;
	localparam int groupLsb = 14;
	localparam int regAMsb = 9;
	localparam int regALsb = 7;
	localparam int regBMsb = 6;
	localparam int regBLsb = 4;

	// ALU group.
	localparam int aluOpMsb = 13;
	localparam int aluOpLsb = 10;
	localparam int immMsb = 3;
	localparam int immLsb = 0;

	// Memory group.
	localparam int storeBit = 13;

	// Jump group.
	localparam int condKindMsb = 13;
	localparam int condKindLsb = 12;
	localparam int condBit = 11;
	localparam int invertBit = 10;
	localparam int relativeBit = 9;
	localparam int offsetMsb = 8;
	localparam int offsetLsb = 0;

endpackage

`default_nettype wire

// ==== forthCore.f ====
+incdir+.
cpuIsaPkg.sv
cpuCtrlPkg.sv
phaseSequencer.sv
instructionDecoder.sv
fullAlu.sv
registerFile.sv
programCounter.sv
forthCore.sv
tbForthCore.sv

// ==== forthCore.sv ====
// Forth core top level without pin bindings.
// Wires sequencer, decoder, registers, ALU and PC, and drives the memory bus.
`timescale 1ns/1ps
`default_nettype none

module forthCore import cpuIsaPkg::*, cpuCtrlPkg::*; #(
	parameter dataWord resetVector = 16'h0000
) (
	input  logic    CLK,
	input  logic    arstN,
	output logic    fetch,
	output logic    decode,
	output logic    execute,
	output logic    commit,
	output dataWord abus,
	output dataWord dbusOut,
	input  dataWord dbusIn,
	output logic    rd,
	output logic    wr
);

	regIndex regASel, regBSel;
	logic regWrite;
	regDataSel regDataSrc;
	aluOpcode aluOp;
	logic [3:0] immediate;
	logic useImm, aluLoad, flagLoad;
	logic pcLoad, jumpRelative, jumpCond, condInvert;
	condSelect condKind;
	logic [8:0] jumpOffset;
	addrSel addrSource;
	dataWord regAData, regBData, aluResult, pcAddr;
	logic flagZero, flagCarry, flagSign, flagParity;

	phaseSequencer i_phaseSequencer (
		.CLK(CLK), .arstN(arstN),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit)
	);

	instructionDecoder i_instructionDecoder (
		.CLK(CLK), .arstN(arstN),
		.fetch(fetch), .execute(execute), .commit(commit), .dbusIn(dbusIn),
		.regASel(regASel), .regBSel(regBSel), .regWrite(regWrite), .regDataSrc(regDataSrc),
		.aluOp(aluOp), .immediate(immediate), .useImm(useImm),
		.aluLoad(aluLoad), .flagLoad(flagLoad),
		.pcLoad(pcLoad), .jumpRelative(jumpRelative), .jumpCond(jumpCond),
		.condInvert(condInvert), .condKind(condKind), .jumpOffset(jumpOffset),
		.addrSource(addrSource), .rd(rd), .wr(wr)
	);

	registerFile i_registerFile (
		.CLK(CLK), .arstN(arstN), .commit(commit), .execute(execute),
		.regASel(regASel), .regBSel(regBSel), .regWrite(regWrite), .regDataSrc(regDataSrc),
		.aluResult(aluResult), .dbusIn(dbusIn),
		.regAData(regAData), .regBData(regBData)
	);

	fullAlu i_fullAlu (
		.CLK(CLK), .arstN(arstN), .execute(execute), .aluOp(aluOp),
		.regAData(regAData), .regBData(regBData), .immediate(immediate),
		.useImm(useImm), .aluLoad(aluLoad), .flagLoad(flagLoad), .aluResult(aluResult),
		.flagZero(flagZero), .flagCarry(flagCarry), .flagSign(flagSign), .flagParity(flagParity)
	);

	programCounter #(.resetVector(resetVector)) i_programCounter (
		.CLK(CLK), .arstN(arstN), .commit(commit), .pcLoad(pcLoad),
		.jumpRelative(jumpRelative), .jumpCond(jumpCond), .condInvert(condInvert),
		.condKind(condKind), .jumpOffset(jumpOffset), .regBData(regBData),
		.flagZero(flagZero), .flagCarry(flagCarry), .flagSign(flagSign), .flagParity(flagParity),
		.pcAddr(pcAddr)
	);

	// Register B addresses memory only while a load or store executes.
	assign abus = (execute && (addrSource == addrRegB)) ? regBData : pcAddr;
	assign dbusOut = regAData;

endmodule

`default_nettype wire

// ==== fullAlu.sv ====
// ALU with result and condition flag registers.
// Operand B is a register or the 4-bit immediate; carry comes from a 17-bit path.
`timescale 1ns/1ps
`default_nettype none

module fullAlu import cpuIsaPkg::*; (
	input  logic       CLK,
	input  logic       arstN,
	input  logic       execute,
	input  aluOpcode   aluOp,
	input  dataWord    regAData,
	input  dataWord    regBData,
	input  logic [3:0] immediate,
	input  logic       useImm,
	input  logic       aluLoad,
	input  logic       flagLoad,
	output dataWord    aluResult,
	output logic       flagZero,
	output logic       flagCarry,
	output logic       flagSign,
	output logic       flagParity
);

	dataWord operandB;
	logic [16:0] wideResult;

	assign operandB = useImm ? {12'd0, immediate} : regBData;

	always_comb begin
		case (aluOp)
			opAdd, opAddi: wideResult = {1'b0, regAData} + {1'b0, operandB};
			// Bit 16 is the borrow.
			opSub, opCmp: wideResult = {1'b0, regAData} - {1'b0, operandB};
			opAnd: wideResult = {1'b0, regAData & operandB};
			opOr: wideResult = {1'b0, regAData | operandB};
			opXor: wideResult = {1'b0, regAData ^ operandB};
			opMov: wideResult = {1'b0, operandB};
			opShl: wideResult = {regAData, 1'b0};
			opShr: wideResult = {regAData[0], 1'b0, regAData[15:1]};
			default: wideResult = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (execute && aluLoad) begin
			aluResult <= wideResult[15:0];
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			flagZero <= 1'b0;
			flagCarry <= 1'b0;
			flagSign <= 1'b0;
			flagParity <= 1'b0;
		end else if (execute && flagLoad) begin
			flagZero <= (wideResult[15:0] == 16'd0);
			flagCarry <= wideResult[16];
			flagSign <= wideResult[15];
			flagParity <= ^wideResult[15:0];
		end
	end

endmodule

`default_nettype wire

// ==== instructionDecoder.sv ====
// Instruction decoder.
// Holds the fetched instruction and splits it into register, ALU, bus and PC controls.
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder import cpuIsaPkg::*, cpuCtrlPkg::*; (
	input  logic       CLK,
	input  logic       arstN,
	input  logic       fetch,
	input  logic       execute,
	input  logic       commit,
	input  dataWord    dbusIn,
	output regIndex    regASel,
	output regIndex    regBSel,
	output logic       regWrite,
	output regDataSel  regDataSrc,
	output aluOpcode   aluOp,
	output logic [3:0] immediate,
	output logic       useImm,
	output logic       aluLoad,
	output logic       flagLoad,
	output logic       pcLoad,
	output logic       jumpRelative,
	output logic       jumpCond,
	output logic       condInvert,
	output condSelect  condKind,
	output logic [8:0] jumpOffset,
	output addrSel     addrSource,
	output logic       rd,
	output logic       wr
);

	dataWord instrReg;
	instrGroup group;
	logic isAlu;
	logic isCmp;
	logic isLoad;
	logic isStore;

	// Reset leaves a nop in the instruction register.
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			instrReg <= {nopGroup, 14'd0};
		end else if (fetch) begin
			instrReg <= dbusIn;
		end
	end

	assign group = instrGroup'(instrReg[groupMsb:groupLsb]);
	assign isAlu = (group == aluGroup);
	assign isCmp = isAlu && (aluOp == opCmp);
	assign isLoad = (group == memGroup) && !instrReg[storeBit];
	assign isStore = (group == memGroup) && instrReg[storeBit];

	assign regASel = instrReg[regAMsb:regALsb];
	assign regBSel = instrReg[regBMsb:regBLsb];
	assign regWrite = (isAlu && !isCmp) || isLoad;
	assign regDataSrc = isAlu ? selAlu : (isLoad ? selBus : selNone);

	assign aluOp = aluOpcode'(instrReg[aluOpMsb:aluOpLsb]);
	assign immediate = instrReg[immMsb:immLsb];
	assign useImm = isAlu && (aluOp == opAddi);
	// Compare keeps the old result but still sets the flags.
	assign aluLoad = isAlu && !isCmp;
	assign flagLoad = isAlu;

	assign pcLoad = (group == jumpGroup);
	assign jumpRelative = instrReg[relativeBit];
	assign jumpCond = instrReg[condBit];
	assign condInvert = instrReg[invertBit];
	assign condKind = condSelect'(instrReg[condKindMsb:condKindLsb]);
	assign jumpOffset = instrReg[offsetMsb:offsetLsb];

	assign addrSource = (group == memGroup) ? addrRegB : addrPc;
	assign rd = fetch || (execute && isLoad);
	assign wr = execute && isStore;

	noReadWhileWrite: assert property (@(posedge CLK) disable iff (!arstN)
		!(rd && wr));

	storeThenCommit: assert property (@(posedge CLK) disable iff (!arstN)
		wr |=> commit);

endmodule

`default_nettype wire

// ==== phaseSequencer.sv ====
// Phase sequencer.
// Steps every instruction through fetch, decode, execute and commit.
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer import cpuCtrlPkg::*; (
	input  logic CLK,
	input  logic arstN,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	cpuPhase phase;
	logic running;

	// First edge after reset only starts the ring, fetch follows.
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			phase <= phaseFetch;
		end else if (!running) begin
			running <= 1'b1;
		end else begin
			phase <= cpuPhase'(phase + 2'd1);
		end
	end

	assign fetch = running && (phase == phaseFetch);
	assign decode = running && (phase == phaseDecode);
	assign execute = running && (phase == phaseExecute);
	assign commit = running && (phase == phaseCommit);

	onePhaseActive: assert property (@(posedge CLK) disable iff (!arstN)
		running |-> $onehot({fetch, decode, execute, commit}));

endmodule

`default_nettype wire

// ==== programCounter.sv ====
// Program counter.
// Steps by one or takes an absolute, relative or conditional jump at commit.
`timescale 1ns/1ps
`default_nettype none

module programCounter import cpuIsaPkg::*; #(
	parameter dataWord resetVector = 16'h0000
) (
	input  logic       CLK,
	input  logic       arstN,
	input  logic       commit,
	input  logic       pcLoad,
	input  logic       jumpRelative,
	input  logic       jumpCond,
	input  logic       condInvert,
	input  condSelect  condKind,
	input  logic [8:0] jumpOffset,
	input  dataWord    regBData,
	input  logic       flagZero,
	input  logic       flagCarry,
	input  logic       flagSign,
	input  logic       flagParity,
	output dataWord    pcAddr
);

	dataWord nextAddr;
	dataWord relTarget;
	logic condFlag;
	logic taken;

	assign nextAddr = pcAddr + 16'd1;
	assign relTarget = nextAddr + {{7{jumpOffset[8]}}, jumpOffset};

	always_comb begin
		case (condKind)
			condZero: condFlag = flagZero;
			condCarry: condFlag = flagCarry;
			condSign: condFlag = flagSign;
			default: condFlag = flagParity;
		endcase
	end

	// Unconditional jumps are always taken.
	assign taken = pcLoad && (!jumpCond || (condFlag ^ condInvert));

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pcAddr <= resetVector;
		end else if (commit) begin
			if (!taken) begin
				pcAddr <= nextAddr;
			end else if (jumpRelative) begin
				pcAddr <= relTarget;
			end else begin
				pcAddr <= regBData;
			end
		end
	end

endmodule

`default_nettype wire

// ==== registerFile.sv ====
// Register file of eight 16-bit registers.
// Two combinational read ports, one write port fed by the ALU or the data bus.
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuIsaPkg::*, cpuCtrlPkg::*; (
	input  logic      CLK,
	input  logic      arstN,
	input  logic      commit,
	input  logic      execute,
	input  regIndex   regASel,
	input  regIndex   regBSel,
	input  logic      regWrite,
	input  regDataSel regDataSrc,
	input  dataWord   aluResult,
	input  dataWord   dbusIn,
	output dataWord   regAData,
	output dataWord   regBData
);

	dataWord regs [8];
	dataWord loadData;

	// Load data is only valid on the bus during execute.
	always_ff @(posedge CLK) begin
		if (execute) begin
			loadData <= dbusIn;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (commit && regWrite) begin
			case (regDataSrc)
				selAlu: regs[regASel] <= aluResult;
				selBus: regs[regASel] <= loadData;
				default: ;
			endcase
		end
	end

	assign regAData = regs[regASel];
	assign regBData = regs[regBSel];

endmodule

`default_nettype wire

// ==== tbIsaModel.svh ====
// Reference model of the forth core instruction set.
// Random source, one-instruction step on the model state, and instruction encoders.
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

function automatic dataWord encodeAlu(input aluOpcode op, input int ra, input int rb,
		input int imm);
	return {2'b00, op, 3'(ra), 3'(rb), 4'(imm)};
endfunction

function automatic dataWord encodeMem(input bit store, input int ra, input int rb);
	return {2'b01, store, 3'd0, 3'(ra), 3'(rb), 4'd0};
endfunction

function automatic dataWord encodeJump(input int kind, input bit cond, input bit inv,
		input bit rel, input int off);
	return {2'b10, 2'(kind), cond, inv, rel, 9'(off)};
endfunction

// Executes one instruction on the model registers, flags, PC and memory.
function automatic void stepModel(input dataWord instr);
	dataWord a;
	dataWord b;
	dataWord nextPc;
	logic [16:0] w;
	logic flag;
	a = modelRegs[instr[9:7]];
	b = modelRegs[instr[6:4]];
	nextPc = modelPc + 16'd1;
	case (instr[15:14])
		2'b00: begin
			if (instr[13:10] == opAddi)
				b = {12'd0, instr[3:0]};
			case (instr[13:10])
				opAdd, opAddi: w = {1'b0, a} + {1'b0, b};
				opSub, opCmp: w = {1'b0, a} - {1'b0, b};
				opAnd: w = {1'b0, a & b};
				opOr: w = {1'b0, a | b};
				opXor: w = {1'b0, a ^ b};
				opMov: w = {1'b0, b};
				opShl: w = {a[15], a[14:0], 1'b0};
				opShr: w = {a[0], 1'b0, a[15:1]};
				default: w = '0;
			endcase
			modelFlags = {w[15:0] == 16'd0, w[16], w[15], ^w[15:0]};
			if (instr[13:10] != opCmp)
				modelRegs[instr[9:7]] = w[15:0];
		end
		2'b01: begin
			if (instr[13]) begin
				storePending = 1'b1;
				expAddr = b;
				expData = a;
				modelMem[b[5:0]] = a;
			end else begin
				modelRegs[instr[9:7]] = modelMem[b[5:0]];
			end
		end
		2'b10: begin
			// Flags are held as zero, carry, sign, parity from bit 3 down.
			flag = modelFlags[3 - instr[13:12]] ^ instr[10];
			if (!instr[11] || flag)
				nextPc = instr[9] ? nextPc + {{7{instr[8]}}, instr[8:0]} : b;
		end
		default: ;
	endcase
	modelPc = nextPc;
endfunction

`endif

// ==== tbForthCore.sv ====
// Testbench for the forth core.
// Runs directed and random programs against a reference model.
`timescale 1ns/1ps
`default_nettype none

module tbForthCore import cpuIsaPkg::*; ();

	localparam dataWord resetVector = 16'h0010;
	localparam int resetCycles = 10;

	logic CLK = 1'b0;
	logic arstN;
	logic fetch, decode, execute, commit, rd, wr;
	dataWord abus, dbusOut, dbusIn;
	dataWord mem [64];
	dataWord modelMem [64];
	dataWord modelRegs [8];
	dataWord modelPc, expAddr, expData;
	dataWord curInstr;
	logic [3:0] modelFlags;
	logic storePending;
	logic [31:0] rng = 32'd12504;
	int fetchCount, phaseIdx;
	bit seenFetch;
	dataWord prog [$];

	`include "tbIsaModel.svh"

	forthCore #(.resetVector(resetVector)) i_dut (
		.CLK(CLK), .arstN(arstN), .fetch(fetch), .decode(decode), .execute(execute),
		.commit(commit), .abus(abus), .dbusOut(dbusOut), .dbusIn(dbusIn), .rd(rd), .wr(wr)
	);

	always #50 CLK = ~CLK;

	assign dbusIn = rd ? mem[abus[5:0]] : 16'h0000;

	always @(posedge CLK) begin
		if (wr)
			mem[abus[5:0]] <= dbusOut;
	end

	task automatic fail(input string what, input dataWord got, input dataWord exp);
		$display("error: %0t %s is %h, expected %h", $time, what, got, exp);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic checkFetch(input dataWord got, input dataWord exp);
		if (got !== exp)
			fail("fetch address", got, exp);
	endtask

	task automatic checkStore(input dataWord addr, input dataWord data);
		if (!storePending) begin
			$display("A write happened without a store instruction in flight.");
			$display("Errors found");
			$fatal(1);
		end
		if (addr !== expAddr)
			fail("store address", addr, expAddr);
		if (data !== expData)
			fail("store data", data, expData);
		storePending = 1'b0;
	endtask

	task automatic checkStrobes(input string what, input logic [3:0] got,
			input logic [3:0] exp);
		if (got !== exp)
			fail(what, {12'd0, got}, {12'd0, exp});
	endtask

	// Expected rd and wr for a phase index and the instruction in flight.
	function automatic logic [1:0] expectedStrobes(input int phase, input dataWord instr);
		logic isMem;
		isMem = (instr[15:14] == 2'b01);
		case (phase)
			0: return 2'b10;
			2: return {isMem && !instr[13], isMem && instr[13]};
			default: return 2'b00;
		endcase
	endfunction

	always @(posedge CLK) begin
		if (!arstN) begin
			checkStrobes("phase strobes", {fetch, decode, execute, commit}, 4'd0);
			checkStrobes("bus strobes", {2'b00, rd, wr}, 4'd0);
			fetchCount = 0;
			phaseIdx = 0;
			seenFetch = 0;
			storePending = 1'b0;
		end else if ({fetch, decode, execute, commit} == 4'd0 && !seenFetch) begin
			checkStrobes("bus strobes", {2'b00, rd, wr}, 4'd0);
		end else begin
			checkStrobes("phase strobes", {fetch, decode, execute, commit},
				4'b1000 >> phaseIdx);
			checkStrobes("bus strobes", {2'b00, rd, wr},
				{2'b00, expectedStrobes(phaseIdx, curInstr)});
			phaseIdx = (phaseIdx + 1) % 4;
			seenFetch = 1;
			if (wr)
				checkStore(abus, dbusOut);
			if (fetch) begin
				checkFetch(abus, modelPc);
				curInstr = modelMem[modelPc[5:0]];
				stepModel(curInstr);
				fetchCount++;
			end
		end
	end

	// Resets the core with the program in memory and runs count instructions.
	task automatic runProgram(input bit randomFill, input int count);
		int cycles;
		int limit;
		limit = 4 * count + resetCycles + 20;
		@(posedge CLK);
		arstN <= 1'b0;
		// Memory and model are loaded while the core is held in reset.
		@(posedge CLK);
		for (int i = 0; i < 64; i++) begin
			rng = xorshift(rng);
			mem[i] = randomFill ? randomInstr(rng) : 16'hC000;
		end
		foreach (prog[i])
			mem[(16 + i) % 64] = prog[i];
		modelMem = mem;
		modelRegs = '{default: 16'h0000};
		modelFlags = 4'd0;
		modelPc = resetVector;
		repeat (resetCycles - 1) @(posedge CLK);
		arstN <= 1'b1;
		cycles = resetCycles;
		while (fetchCount < count || !arstN) begin
			@(posedge CLK);
			cycles++;
			if (cycles > limit) begin
				$display("The core stalled: only %0d of %0d instructions were fetched.",
					fetchCount, count);
				$display("Errors found");
				$fatal(1);
			end
		end
		// Let the last instruction finish its store and commit.
		repeat (4) @(posedge CLK);
	endtask

	function automatic dataWord randomInstr(input logic [31:0] r);
		case (r[2:0])
			3'd0, 3'd1, 3'd2: return encodeAlu(aluOpcode'(r[12:9] % 10), r[15:13], r[18:16],
				r[22:19]);
			3'd3: return encodeMem(r[9], r[15:13], r[18:16]);
			// Absolute targets come from registers and wrap in the 64-word memory.
			3'd4, 3'd5: return encodeJump(r[10:9], r[11], r[12], r[13] | r[14],
				r[13] | r[14] ? int'(r[19:16]) - 8 : {r[18:16], 4'd0});
			default: return 16'hC000;
		endcase
	endfunction

	initial begin
		arstN = 1'b0;
		fetchCount = 0;
		// ALU opcodes, stores of all registers, then a store and load round trip.
		prog = {encodeAlu(opAddi, 1, 0, 15), encodeAlu(opAddi, 2, 0, 7),
			encodeAlu(opMov, 3, 1, 0), encodeAlu(opAdd, 3, 2, 0), encodeAlu(opSub, 4, 1, 0),
			encodeAlu(opMov, 5, 3, 0), encodeAlu(opAnd, 5, 2, 0), encodeAlu(opMov, 6, 1, 0),
			encodeAlu(opOr, 6, 2, 0), encodeAlu(opMov, 7, 3, 0), encodeAlu(opXor, 7, 1, 0),
			encodeAlu(opShl, 1, 0, 0), encodeAlu(opShr, 2, 0, 0), encodeAlu(opCmp, 3, 3, 0)};
		for (int r = 0; r < 8; r++)
			prog.push_back(encodeMem(1, r, 0));
		prog = {prog, encodeMem(1, 3, 2), encodeMem(0, 4, 2), encodeMem(1, 4, 1)};
		runProgram(0, prog.size());
		// Every condition with and without invert on two contrasting flag sets.
		prog = {encodeAlu(opCmp, 0, 0, 0)};
		for (int s = 0; s < 2; s++) begin
			if (s == 1)
				prog = {prog, encodeAlu(opAddi, 7, 0, 15), encodeAlu(opCmp, 0, 7, 0)};
			for (int k = 0; k < 8; k++)
				prog = {prog, encodeJump(k / 2, 1, k % 2, 1, 1), 16'hC000};
		end
		// Backward loop, forward skip, then an absolute jump through r5.
		prog = {prog, encodeAlu(opAddi, 4, 0, 3), encodeAlu(opAddi, 3, 0, 1),
			encodeAlu(opCmp, 3, 4, 0), encodeJump(0, 1, 1, 1, -3), encodeJump(0, 0, 0, 1, 2),
			encodeAlu(opAddi, 6, 0, 1), encodeAlu(opAddi, 6, 0, 1), encodeAlu(opAddi, 5, 0, 15),
			encodeAlu(opAddi, 5, 0, 3), encodeJump(0, 0, 0, 0, {2'b00, 3'd5, 4'd0})};
		runProgram(0, prog.size() + 30);
		prog = {};
		runProgram(1, 200);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
